//--- hw/qspi_config.svh
`ifndef QSPI_CONFIG_SVH
`define QSPI_CONFIG_SVH

// Data FIFO entries, also the credit count after reset
`define QSPI_FIFO_DEPTH 16

// Bytes in the flash address phase
`define QSPI_ADDR_BYTES 3

// Register offsets
`define QSPI_REG_CCR 8'h00
`define QSPI_REG_ADR 8'h04
`define QSPI_REG_DR  8'h08
`define QSPI_REG_STA 8'h28

`endif

//--- hw/qspi_pkg.sv
`default_nettype none

package qspi_pkg;

    typedef enum logic [1:0] {
        MODE_NONE = 2'b00,
        MODE_X1   = 2'b01,
        MODE_X2   = 2'b10,
        MODE_X4   = 2'b11
    } data_mode_e;

    // Command control word as written by the host
    typedef struct packed {
        logic        clear_status;
        logic [5:0]  prescaler;
        logic [5:0]  reserved;
        logic [3:0]  data_length;
        logic [4:0]  dummy_cycles;
        data_mode_e  data_mode;
        logic [7:0]  instruction;
    } ccr_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic        start;
        ccr_t        ccr;
        logic        has_addr;
        logic [23:0] addr;
    } cmd_t;

    typedef struct packed {
        logic busy;
        logic done;
    } status_t;

    typedef struct packed {
        logic rise;
        logic fall;
    } sclk_tick_t;

    // dq_oen bit set means the lane is an input
    typedef struct packed {
        logic       sclk;
        logic       cs_n;
        logic [3:0] dq;
        logic [3:0] dq_oen;
    } qspi_pins_t;

endpackage

`default_nettype wire

//--- hw/qspi_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "qspi_config.svh"

module qspi_regs import qspi_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  reg_req_t    reg_req_i,
    output logic [31:0] reg_rdata_o,
    input  status_t     status_i,
    output cmd_t        cmd_o,
    output logic        push_o,
    output logic [7:0]  push_byte_o,
    input  logic        credit_i
);

    ccr_t        ccr_q;
    ccr_t        wr_ccr;
    logic [23:0] adr_q;
    logic        has_addr_q;
    logic        start_q;
    logic        push_q;
    logic [7:0]  push_byte_q;
    logic        overflow_q;
    logic [4:0]  credits_q;
    logic [31:0] rdata_q;
    logic        wr_en;
    logic        rd_en;
    logic        ccr_wr;
    logic        dr_wr;
    logic        take;

    assign wr_en  = reg_req_i.valid && reg_req_i.write;
    assign rd_en  = reg_req_i.valid && !reg_req_i.write;
    assign ccr_wr = wr_en && (reg_req_i.addr == `QSPI_REG_CCR);
    assign dr_wr  = wr_en && (reg_req_i.addr == `QSPI_REG_DR);
    assign wr_ccr = reg_req_i.wdata;
    // A push is only allowed while the FIFO has room
    assign take   = dr_wr && (credits_q != 5'd0);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ccr_q      <= '0;
            adr_q      <= '0;
            has_addr_q <= 1'b0;
            start_q    <= 1'b0;
            push_q     <= 1'b0;
            overflow_q <= 1'b0;
            credits_q  <= 5'(`QSPI_FIFO_DEPTH);
        end else begin
            start_q            <= 1'b0;
            push_q             <= take;
            ccr_q.clear_status <= 1'b0;
            credits_q          <= credits_q + {4'b0, credit_i} - {4'b0, take};
            if (ccr_wr) begin
                if (wr_ccr.clear_status) begin
                    ccr_q.clear_status <= 1'b1;
                    overflow_q         <= 1'b0;
                end else if (!status_i.busy && !start_q) begin
                    ccr_q      <= wr_ccr;
                    has_addr_q <= |adr_q;
                    start_q    <= 1'b1;
                end
            end
            if (wr_en && (reg_req_i.addr == `QSPI_REG_ADR)) begin
                adr_q <= reg_req_i.wdata[23:0];
            end
            if (dr_wr && (credits_q == 5'd0)) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            push_byte_q <= reg_req_i.wdata[7:0];
        end
        if (rd_en) begin
            case (reg_req_i.addr)
                `QSPI_REG_ADR: rdata_q <= {8'h00, adr_q};
                `QSPI_REG_STA: rdata_q <= {19'h0, credits_q, 5'h0, overflow_q,
                                           status_i.busy, status_i.done};
                default:       rdata_q <= '0;
            endcase
        end
    end

    always_comb begin
        cmd_o.start    = start_q;
        cmd_o.ccr      = ccr_q;
        cmd_o.has_addr = has_addr_q;
        cmd_o.addr     = adr_q;
    end

    assign push_o      = push_q;
    assign push_byte_o = push_byte_q;
    assign reg_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hw/qspi_byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "qspi_config.svh"

module qspi_byte_fifo (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       push_i,
    input  logic [7:0] push_byte_i,
    input  logic       pop_i,
    output logic [7:0] head_byte_o,
    output logic       head_valid_o,
    output logic       credit_o
);

    localparam int AW = $clog2(`QSPI_FIFO_DEPTH);

    logic [7:0]  mem_q [`QSPI_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          credit_q;

    // No full check, the producer never pushes without a credit
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_byte_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_q + AW'(push_i);
            rd_ptr_q <= rd_ptr_q + AW'(pop_i);
            count_q  <= count_q + {{AW{1'b0}}, push_i} - {{AW{1'b0}}, pop_i};
            // One credit back per byte leaving
            credit_q <= pop_i;
        end
    end

    assign head_byte_o  = mem_q[rd_ptr_q];
    assign head_valid_o = (count_q != '0);
    assign credit_o     = credit_q;

endmodule

`default_nettype wire

//--- hw/qspi_sclk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module qspi_sclk_gen import qspi_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       run_i,
    input  logic [5:0] prescaler_i,
    output logic       sclk_o,
    output sclk_tick_t tick_o
);

    logic [5:0] cnt_q;
    logic       sclk_q;
    sclk_tick_t tick_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni || !run_i) begin
            cnt_q  <= '0;
            sclk_q <= 1'b0;
            tick_q <= '0;
        end else begin
            tick_q <= '0;
            if (cnt_q == prescaler_i) begin
                cnt_q       <= '0;
                sclk_q      <= ~sclk_q;
                // Tick marks the cycle the new level appears
                tick_q.rise <= ~sclk_q;
                tick_q.fall <= sclk_q;
            end else begin
                cnt_q <= cnt_q + 6'd1;
            end
        end
    end

    assign sclk_o = sclk_q;
    assign tick_o = tick_q;

endmodule

`default_nettype wire

//--- hw/qspi_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "qspi_config.svh"

module qspi_sequencer import qspi_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  cmd_t       cmd_i,
    input  logic [7:0] head_byte_i,
    input  logic       head_valid_i,
    output logic       pop_o,
    output logic       run_o,
    output logic [5:0] prescaler_o,
    input  logic       sclk_i,
    input  sclk_tick_t tick_i,
    output qspi_pins_t pins_o,
    output status_t    status_o
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_INSTR, ST_ADDR, ST_DUMMY, ST_DATA, ST_STALL, ST_FINISH
    } state_e;

    state_e      state_q;
    state_e      next_phase;
    state_e      after_addr;
    state_e      after_dummy;
    data_mode_e  mode_q;
    data_mode_e  lane_mode;
    logic [5:0]  prescaler_q;
    logic [3:0]  len_q;
    logic [4:0]  dummy_q;
    logic        has_addr_q;
    logic        run_q;
    logic        done_q;
    logic [31:0] sr_q;
    logic [31:0] sr_shift;
    logic [2:0]  bit_cnt_q;
    logic [2:0]  grp_last;
    logic [3:0]  byte_cnt_q;
    logic [4:0]  dummy_cnt_q;
    logic        byte_done;
    logic        phase_end;
    logic        fetch;
    logic        halt;
    logic [3:0]  dq;
    logic [3:0]  dq_oen;

    // Instruction and address always go out on a single lane
    always_comb begin
        lane_mode = (state_q == ST_DATA || state_q == ST_STALL) ? mode_q : MODE_X1;
        case (lane_mode)
            MODE_X2: begin
                sr_shift = {sr_q[29:0], 2'b00};
                dq       = {2'b00, sr_q[31:30]};
                dq_oen   = 4'hC;
                grp_last = 3'd3;
            end
            MODE_X4: begin
                sr_shift = {sr_q[27:0], 4'h0};
                dq       = sr_q[31:28];
                dq_oen   = 4'h0;
                grp_last = 3'd1;
            end
            default: begin
                sr_shift = {sr_q[30:0], 1'b0};
                dq       = {3'b000, sr_q[31]};
                dq_oen   = 4'hE;
                grp_last = 3'd7;
            end
        endcase
        if (state_q inside {ST_IDLE, ST_DUMMY, ST_FINISH}) begin
            dq_oen = 4'hF;
        end
    end

    always_comb begin
        after_dummy = (mode_q != MODE_NONE) ? ST_DATA : ST_FINISH;
        after_addr  = (dummy_q != 5'd0) ? ST_DUMMY : after_dummy;
        byte_done   = (bit_cnt_q == grp_last);
        phase_end   = 1'b0;
        next_phase  = ST_FINISH;
        case (state_q)
            ST_INSTR: begin
                phase_end  = byte_done;
                next_phase = has_addr_q ? ST_ADDR : after_addr;
            end
            ST_ADDR: begin
                phase_end  = byte_done && (byte_cnt_q == 4'(`QSPI_ADDR_BYTES - 1));
                next_phase = after_addr;
            end
            ST_DUMMY: begin
                phase_end  = (dummy_cnt_q == dummy_q - 5'd1);
                next_phase = after_dummy;
            end
            ST_DATA: begin
                phase_end  = byte_done && (byte_cnt_q == len_q);
                next_phase = ST_FINISH;
            end
            default: ;
        endcase
        // Next data byte is needed at this fall
        fetch = tick_i.fall && (phase_end ? (next_phase == ST_DATA)
                                          : (state_q == ST_DATA && byte_done));
        // Stop sclk while it is low, before the next rise
        halt  = (fetch && !head_valid_i) ||
                (tick_i.fall && phase_end && next_phase == ST_FINISH);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q     <= ST_IDLE;
            run_q       <= 1'b0;
            done_q      <= 1'b0;
            bit_cnt_q   <= '0;
            byte_cnt_q  <= '0;
            dummy_cnt_q <= '0;
        end else begin
            if (cmd_i.ccr.clear_status) begin
                done_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (cmd_i.start) begin
                        mode_q      <= cmd_i.ccr.data_mode;
                        prescaler_q <= cmd_i.ccr.prescaler;
                        len_q       <= cmd_i.ccr.data_length;
                        dummy_q     <= cmd_i.ccr.dummy_cycles;
                        has_addr_q  <= cmd_i.has_addr;
                        sr_q        <= {cmd_i.ccr.instruction, cmd_i.addr};
                        bit_cnt_q   <= '0;
                        byte_cnt_q  <= '0;
                        dummy_cnt_q <= '0;
                        run_q       <= 1'b1;
                        state_q     <= ST_INSTR;
                    end
                end
                ST_STALL: begin
                    if (head_valid_i) begin
                        sr_q    <= {head_byte_i, 24'h0};
                        run_q   <= 1'b1;
                        state_q <= ST_DATA;
                    end
                end
                ST_FINISH: state_q <= ST_IDLE;
                default: begin
                    if (tick_i.fall) begin
                        if (state_q == ST_DUMMY) begin
                            dummy_cnt_q <= dummy_cnt_q + 5'd1;
                        end else begin
                            sr_q      <= sr_shift;
                            bit_cnt_q <= byte_done ? 3'd0 : bit_cnt_q + 3'd1;
                            if (byte_done) begin
                                byte_cnt_q <= byte_cnt_q + 4'd1;
                            end
                        end
                        if (phase_end) begin
                            state_q    <= next_phase;
                            byte_cnt_q <= '0;
                        end
                        if (fetch && head_valid_i) begin
                            sr_q <= {head_byte_i, 24'h0};
                        end else if (fetch) begin
                            state_q <= ST_STALL;
                            run_q   <= 1'b0;
                        end
                        if (phase_end && next_phase == ST_FINISH) begin
                            run_q  <= 1'b0;
                            done_q <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign pop_o       = head_valid_i && (fetch || state_q == ST_STALL);
    assign run_o       = run_q && !halt;
    assign prescaler_o = prescaler_q;

    always_comb begin
        pins_o.sclk     = sclk_i;
        pins_o.cs_n     = (state_q == ST_IDLE || state_q == ST_FINISH);
        pins_o.dq       = dq;
        pins_o.dq_oen   = dq_oen;
        status_o.busy   = !(state_q == ST_IDLE || state_q == ST_FINISH);
        status_o.done   = done_q;
    end

endmodule

`default_nettype wire

//--- hw/qspi_master.sv
`timescale 1ns/1ns
`default_nettype none

module qspi_master import qspi_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  reg_req_t    reg_req_i,
    output logic [31:0] reg_rdata_o,
    output qspi_pins_t  qspi_o
);

    cmd_t       cmd;
    status_t    status;
    logic       push;
    logic [7:0] push_byte;
    logic       credit;
    logic [7:0] head_byte;
    logic       head_valid;
    logic       pop;
    logic       run;
    logic [5:0] prescaler;
    logic       sclk;
    sclk_tick_t tick;

    qspi_regs u_regs (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .reg_req_i   (reg_req_i),
        .reg_rdata_o (reg_rdata_o),
        .status_i    (status),
        .cmd_o       (cmd),
        .push_o      (push),
        .push_byte_o (push_byte),
        .credit_i    (credit)
    );

    qspi_byte_fifo u_fifo (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (push),
        .push_byte_i  (push_byte),
        .pop_i        (pop),
        .head_byte_o  (head_byte),
        .head_valid_o (head_valid),
        .credit_o     (credit)
    );

    qspi_sclk_gen u_sclk (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .run_i       (run),
        .prescaler_i (prescaler),
        .sclk_o      (sclk),
        .tick_o      (tick)
    );

    qspi_sequencer u_seq (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cmd_i        (cmd),
        .head_byte_i  (head_byte),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .run_o        (run),
        .prescaler_o  (prescaler),
        .sclk_i       (sclk),
        .tick_i       (tick),
        .pins_o       (qspi_o),
        .status_o     (status)
    );

endmodule

`default_nettype wire

//--- bench/qspi_master_props.sv
`timescale 1ns/1ns
`default_nettype none

module qspi_master_props import qspi_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input qspi_pins_t qspi_o
);

    int unsigned fail_cnt = 0;

    // Deselected flash sees released lanes and a parked clock
    idle_pins: assert property (@(posedge clk_i) disable iff (!rst_ni)
        qspi_o.cs_n |-> (qspi_o.dq_oen == 4'hF && !qspi_o.sclk))
        else begin
            fail_cnt++;
            $error("dq_oen or sclk active while cs_n is high");
        end

    cs_fall_sclk_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(qspi_o.cs_n) |-> (!qspi_o.sclk && !$past(qspi_o.sclk)))
        else begin
            fail_cnt++;
            $error("cs_n fell while sclk was high");
        end

endmodule

`default_nettype wire

//--- bench/qspi_master_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "qspi_config.svh"

module qspi_master_tb import qspi_pkg::*; ();

    localparam int MAX_TXN   = 32;
    localparam int TXN_WORDS = 23;

    logic        clk_i;
    logic        rst_ni;
    reg_req_t    reg_req;
    logic [31:0] reg_rdata;
    qspi_pins_t  qspi;

    logic [31:0]     stim [MAX_TXN*TXN_WORDS+1];
    int unsigned     checks;
    int unsigned     errors;
    longint unsigned limit_ns;

    // Frame shape expected by the pin monitor
    int unsigned exp_width;
    bit          exp_has_addr;
    int unsigned exp_data_at;

    int unsigned mon_rises;
    int unsigned mon_bits;
    logic        mon_sclk;
    logic [7:0]  mon_instr;
    logic [23:0] mon_addr;
    logic [7:0]  mon_shift;
    logic [7:0]  mon_bytes [$];

    qspi_master dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .reg_req_i   (reg_req),
        .reg_rdata_o (reg_rdata),
        .qspi_o      (qspi)
    );

    bind qspi_master qspi_master_props u_props (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .qspi_o (qspi_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    function automatic int unsigned lane_width(input logic [1:0] mode);
        case (mode)
            2'd3:    return 4;
            2'd2:    return 2;
            default: return 1;
        endcase
    endfunction

    function automatic logic [3:0] lane_oen(input int unsigned width);
        case (width)
            4:       return 4'h0;
            2:       return 4'hC;
            default: return 4'hE;
        endcase
    endfunction

    // Instruction, optional address, dummy clocks, then data
    function automatic int unsigned frame_rises(input int unsigned t);
        int unsigned base;
        base = 1 + t * TXN_WORDS;
        return 8 + ((stim[base+2][23:0] != 24'h0) ? 24 : 0) + stim[base+3]
               + stim[base+5] * 8 / lane_width(stim[base][1:0]);
    endfunction

    // Sampled mid-cycle so sclk and dq are settled
    always @(negedge clk_i) begin
        logic [3:0] oen_exp;
        if (qspi.sclk && !mon_sclk && !qspi.cs_n) begin
            if (mon_rises < 8) begin
                oen_exp   = 4'hE;
                mon_instr = {mon_instr[6:0], qspi.dq[0]};
            end else if (exp_has_addr && mon_rises < 32) begin
                oen_exp  = 4'hE;
                mon_addr = {mon_addr[22:0], qspi.dq[0]};
            end else if (mon_rises < exp_data_at) begin
                oen_exp = 4'hF;
            end else begin
                oen_exp = lane_oen(exp_width);
                for (int i = exp_width - 1; i >= 0; i--) begin
                    mon_shift = {mon_shift[6:0], qspi.dq[i]};
                end
                mon_bits += exp_width;
                if (mon_bits == 8) begin
                    mon_bytes.push_back(mon_shift);
                    mon_bits = 0;
                end
            end
            checks++;
            if (qspi.dq_oen !== oen_exp) begin
                errors++;
                $display("Mismatch dq_oen at rise %0d: got %h expected %h",
                         mon_rises, qspi.dq_oen, oen_exp);
            end
            mon_rises++;
        end
        mon_sclk = qspi.sclk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        reg_req = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge clk_i);
        #1;
        reg_req = '0;
    endtask

    // One idle cycle first so earlier writes have settled
    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk_i);
        #1;
        reg_req = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
        @(posedge clk_i);
        #1;
        reg_req = '0;
        data = reg_rdata;
    endtask

    task automatic wait_cs(input logic level, input int unsigned max_cycles);
        int unsigned n;
        n = 0;
        while (qspi.cs_n !== level && n < max_cycles) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        checks++;
        if (qspi.cs_n !== level) begin
            errors++;
            $display("cs_n did not go %0s within %0d cycles", level ? "high" : "low",
                     max_cycles);
        end
    endtask

    task automatic run_txn(input int unsigned t);
        int unsigned base;
        int unsigned dummy;
        int unsigned presc;
        int unsigned count;
        int unsigned kind;
        int unsigned pre;
        logic [23:0] addr;
        logic [31:0] rdata;
        ccr_t        ccr;
        base  = 1 + t * TXN_WORDS;
        addr  = stim[base+2][23:0];
        dummy = stim[base+3];
        presc = stim[base+4];
        count = stim[base+5];
        kind  = stim[base+6];
        pre   = (kind == 1) ? count / 2 : count;

        exp_width    = lane_width(stim[base][1:0]);
        exp_has_addr = (addr != 24'h0);
        exp_data_at  = 8 + (exp_has_addr ? 24 : 0) + dummy;
        mon_rises    = 0;
        mon_bits     = 0;
        mon_instr    = '0;
        mon_addr     = '0;
        mon_bytes.delete();

        reg_write(`QSPI_REG_ADR, {8'h00, addr});
        reg_read(`QSPI_REG_ADR, rdata);
        check_value("ADR readback", rdata, {8'h00, addr});
        for (int i = 0; i < pre; i++) begin
            reg_write(`QSPI_REG_DR, {24'h0, stim[base+7+i][7:0]});
        end
        if (kind == 2) begin
            // FIFO is full so this byte is refused
            reg_write(`QSPI_REG_DR, 32'h0000_00EE);
            reg_read(`QSPI_REG_STA, rdata);
            check_value("STA after overflow", rdata, 32'h0000_0004);
            reg_write(`QSPI_REG_CCR, 32'h8000_0000);
            reg_read(`QSPI_REG_STA, rdata);
            check_value("STA after overflow clear", rdata, 32'h0000_0000);
        end

        ccr              = '0;
        ccr.prescaler    = presc[5:0];
        ccr.data_length  = 4'(count - 1);
        ccr.dummy_cycles = dummy[4:0];
        ccr.data_mode    = data_mode_e'(stim[base][1:0]);
        ccr.instruction  = stim[base+1][7:0];
        reg_write(`QSPI_REG_CCR, ccr);
        wait_cs(1'b0, 16);

        if (kind == 1) begin
            repeat ($urandom_range(120, 20)) @(posedge clk_i);
            reg_read(`QSPI_REG_STA, rdata);
            check_value("STA busy/done before last bytes", rdata & 32'h3, 32'h2);
            for (int i = pre; i < count; i++) begin
                reg_write(`QSPI_REG_DR, {24'h0, stim[base+7+i][7:0]});
            end
        end
        wait_cs(1'b1, frame_rises(t) * 2 * (presc + 1) + 64);

        check_value("instruction", mon_instr, stim[base+1][7:0]);
        if (exp_has_addr) begin
            check_value("address", mon_addr, addr);
        end
        check_value("sclk rises", mon_rises, frame_rises(t));
        check_value("data byte count", mon_bytes.size(), count);
        for (int i = 0; i < count && i < mon_bytes.size(); i++) begin
            check_value($sformatf("data byte %0d", i), mon_bytes[i], stim[base+7+i][7:0]);
        end

        reg_read(`QSPI_REG_STA, rdata);
        check_value("STA after frame", rdata, 32'h0000_1001);
        reg_write(`QSPI_REG_CCR, 32'h8000_0000);
        reg_read(`QSPI_REG_STA, rdata);
        check_value("STA after clear", rdata, 32'h0000_1000);
    endtask

    initial begin
        longint unsigned total;
        int unsigned     n_txn;
        logic [31:0]     rdata;
        rdata     = $urandom(32'h506dfa5e);
        checks    = 0;
        errors    = 0;
        limit_ns  = 0;
        rst_ni    = 1'b0;
        reg_req   = '0;
        mon_sclk  = 1'b0;
        mon_rises = 0;
        mon_bits  = 0;
        $readmemh("bench/qspi_stim.txt", stim);
        n_txn = stim[0];

        // Serial frame time plus register traffic and stall gaps
        total = 2000;
        for (int t = 0; t < n_txn; t++) begin
            total += frame_rises(t) * 2 * (stim[1+t*TXN_WORDS+4] + 1) * 8 + 4000;
        end
        limit_ns = total;

        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_value("cs_n after reset", qspi.cs_n, 32'h1);
        check_value("dq_oen after reset", qspi.dq_oen, 32'hF);
        reg_read(`QSPI_REG_STA, rdata);
        check_value("STA after reset", rdata, 32'h0000_1000);

        for (int t = 0; t < n_txn; t++) begin
            run_txn(t);
        end

        errors += dut.u_props.fail_cnt;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Timeout after %0d ns, the run did not complete", limit_ns);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/qspi_stim.txt
// Count, then per line: mode (1 x1, 2 x2, 3 x4), instruction, address, dummy, prescaler,
// byte count, kind (0 normal, 1 late push, 2 overflow), 16 data bytes
0C
1 02 000000 00 0 01 0 A5 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 02 012345 00 1 04 0 11 22 33 44 00 00 00 00 00 00 00 00 00 00 00 00
2 A2 0000F0 00 0 03 0 C3 5A 0F 00 00 00 00 00 00 00 00 00 00 00 00 00
2 A2 000000 08 2 02 0 96 69 00 00 00 00 00 00 00 00 00 00 00 00 00 00
3 32 3FFFFF 00 0 05 0 01 23 45 67 89 00 00 00 00 00 00 00 00 00 00 00
3 32 000000 06 1 08 0 FE DC BA 98 76 54 32 10 00 00 00 00 00 00 00 00
1 12 ABCDEF 0A 0 10 0 00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF
3 38 000100 04 0 06 1 5A A5 3C C3 81 18 00 00 00 00 00 00 00 00 00 00
2 02 000000 00 3 03 1 DE AD BE 00 00 00 00 00 00 00 00 00 00 00 00 00
1 02 7F0000 1F 0 02 1 F0 0F 00 00 00 00 00 00 00 00 00 00 00 00 00 00
3 EB 000001 00 0 10 2 B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
2 3B 100000 01 0 01 0 7E 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

//--- files.f
+incdir+hw
hw/qspi_pkg.sv
hw/qspi_regs.sv
hw/qspi_byte_fifo.sv
hw/qspi_sclk_gen.sv
hw/qspi_sequencer.sv
hw/qspi_master.sv
bench/qspi_master_props.sv
bench/qspi_master_tb.sv
